//--- src/codecCfgPkg.sv
////////////////////
//  Codec config constants
////////////////////

package codecCfgPkg;

  ////////////////////
  // Bus addressing

  // Seven-bit codec address 0x1A, R/W bit low for write
  localparam logic [7:0] codecAddrByte = {7'h1A, 1'b0};

  ////////////////////
  // Table geometry

  localparam int tableSize = 11;  // Entries in the config table
  localparam int idxWidth  = 4;   // Index width, covers tableSize

  ////////////////////
  // Word layout

  // Upper 7 bits register number, lower 9 bits value
  localparam int regWordWidth = 16;

  // Address byte in front of the register word
  localparam int xferWidth = 8 + regWordWidth;

endpackage

//--- src/codecRegTable.sv
`timescale 1ns/1ns
////////////////////
//  Codec register table
////////////////////

module codecRegTable (
  input  logic [codecCfgPkg::idxWidth-1:0]     idx,     // Entry index from sequencer
  output logic [codecCfgPkg::regWordWidth-1:0] regWord  // Register word for that entry
);

  // Word is {reg[6:0], value[8:0]}
  always_comb begin
    case (idx)
      4'd0:    regWord = 16'h1E00;  // R15 reset
      4'd1:    regWord = 16'h009A;  // R0 left line in
      4'd2:    regWord = 16'h029A;  // R1 right line in
      4'd3:    regWord = 16'h0479;  // R2 left headphone
      4'd4:    regWord = 16'h0679;  // R3 right headphone
      4'd5:    regWord = 16'h08D2;  // R4 analog path, DAC selected
      4'd6:    regWord = 16'h0A06;  // R5 digital path, de-emphasis
      4'd7:    regWord = 16'h0C00;  // R6 power up everything
      4'd8:    regWord = 16'h0E01;  // R7 format, 16 bit
      4'd9:    regWord = 16'h1009;  // R8 sample rate
      4'd10:   regWord = 16'h1201;  // R9 activate
      default: regWord = 16'h0000;  // Past the end
    endcase
  end

endmodule

//--- src/i2cWriteMaster.sv
`timescale 1ns/1ns
////////////////////
//  I2C write master
////////////////////

module i2cWriteMaster #(
  parameter int CLK_FREQ = 24000000,  // System clock in Hz
  parameter int I2C_FREQ = 20000      // SCL rate in Hz
) (
  input  logic                              iCLK,
  input  logic                              iRST_N,
  input  logic                              xferStart,  // One-cycle go
  input  logic [codecCfgPkg::xferWidth-1:0] xferWord,   // {addr, reg word}
  output logic                              xferBusy,
  output logic                              xferDone,   // One-cycle end pulse
  output logic                              xferAck,    // All bytes acked
  output logic                              i2cSclk,
  inout  wire                               i2cSdat
);

  localparam int QuarterDiv = CLK_FREQ / (4 * I2C_FREQ);  // Clocks per quarter bit
  localparam int DivW       = $clog2(QuarterDiv + 1);
  localparam int XferW      = codecCfgPkg::xferWidth;

  typedef enum logic [1:0] {
    stIdle,
    stStart,
    stData,
    stStop
  } phaseT;

  phaseT            phase;
  logic [DivW-1:0]  divCnt;
  logic             tick;      // Quarter-bit enable
  logic [1:0]       quarter;   // Position inside a bit
  logic [3:0]       bitCnt;    // 0..7 data, 8 ack slot
  logic [1:0]       byteCnt;   // 0 addr, 1..2 word
  logic [XferW-1:0] shiftReg;
  logic             sclReg;
  logic             sdaLow;    // Pull SDA low when set
  logic             ackOk;     // No refusal seen yet

  ////////////////////
  // Quarter-bit tick

  // Free running, the FSM only listens while busy
  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      divCnt <= '0;
    end else if (tick) begin
      divCnt <= '0;
    end else begin
      divCnt <= divCnt + DivW'(1);
    end
  end

  assign tick = (divCnt == DivW'(QuarterDiv - 1));

  ////////////////////
  // Data shifter

  always_ff @(posedge iCLK) begin
    if (phase == stIdle && xferStart) begin
      shiftReg <= xferWord;  // Capture on start
    end else if (tick && phase == stData && quarter == 2'd3 && bitCnt != 4'd8) begin
      shiftReg <= {shiftReg[XferW-2:0], 1'b0};  // Next bit to MSB
    end
  end

  ////////////////////
  // Phase FSM

  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      phase    <= stIdle;
      quarter  <= 2'd0;
      bitCnt   <= 4'd0;
      byteCnt  <= 2'd0;
      sclReg   <= 1'b1;  // Bus idle high
      sdaLow   <= 1'b0;
      ackOk    <= 1'b0;
      xferBusy <= 1'b0;
      xferDone <= 1'b0;
      xferAck  <= 1'b0;
    end else begin
      xferDone <= 1'b0;  // Pulse by default
      if (phase == stIdle) begin
        if (xferStart) begin
          phase    <= stStart;
          quarter  <= 2'd0;
          bitCnt   <= 4'd0;
          byteCnt  <= 2'd0;
          ackOk    <= 1'b1;
          xferBusy <= 1'b1;
        end
      end else if (tick) begin
        quarter <= quarter + 2'd1;  // Wraps into next bit
        case (phase)
          stStart: begin
            // SDA falls with SCL high, then SCL low
            if (quarter == 2'd1) sdaLow <= 1'b1;
            if (quarter == 2'd3) begin
              sclReg <= 1'b0;
              phase  <= stData;
            end
          end
          stData: begin
            case (quarter)
              2'd0: sdaLow <= (bitCnt == 4'd8) ? 1'b0 : ~shiftReg[XferW-1];  // SCL low here
              2'd1: sclReg <= 1'b1;
              2'd2: begin
                if (bitCnt == 4'd8 && i2cSdat) ackOk <= 1'b0;  // Slave left SDA high
              end
              default: begin
                sclReg <= 1'b0;
                if (bitCnt != 4'd8) begin
                  bitCnt <= bitCnt + 4'd1;
                end else if (!ackOk || byteCnt == 2'd2) begin
                  phase <= stStop;  // Refused or last byte
                end else begin
                  bitCnt  <= 4'd0;
                  byteCnt <= byteCnt + 2'd1;
                end
              end
            endcase
          end
          stStop: begin
            // SDA low, SCL up, SDA rises with SCL high
            case (quarter)
              2'd0: sdaLow <= 1'b1;
              2'd1: sclReg <= 1'b1;
              2'd2: sdaLow <= 1'b0;
              default: begin
                phase    <= stIdle;
                xferBusy <= 1'b0;
                xferDone <= 1'b1;
                xferAck  <= ackOk;
              end
            endcase
          end
          default: phase <= stIdle;
        endcase
      end
    end
  end

  assign i2cSclk = sclReg;                 // Push-pull clock
  assign i2cSdat = sdaLow ? 1'b0 : 1'bz;   // Open drain

endmodule

//--- src/codecCfgSequencer.sv
`timescale 1ns/1ns
////////////////////
//  Config sequencer
////////////////////

module codecCfgSequencer #(
  parameter int MAX_RETRY = 3  // Attempts per entry before giving up
) (
  input  logic                                 iCLK,
  input  logic                                 iRST_N,
  output logic [codecCfgPkg::idxWidth-1:0]     idx,
  input  logic [codecCfgPkg::regWordWidth-1:0] regWord,
  output logic                                 xferStart,
  output logic [codecCfgPkg::xferWidth-1:0]    xferWord,
  input  logic                                 xferBusy,
  input  logic                                 xferDone,
  input  logic                                 xferAck,
  output logic                                 cfgDone,  // Sticky
  output logic                                 cfgFail   // Sticky
);

  localparam int IdxW   = codecCfgPkg::idxWidth;
  localparam int RetryW = $clog2(MAX_RETRY + 1);

  typedef enum logic [2:0] {
    stIssue,
    stWait,
    stAdvance,  // End-of-table check
    stDone,
    stFail
  } seqStateT;

  seqStateT          state;
  logic [IdxW-1:0]   idxReg;
  logic [RetryW-1:0] retryCnt;  // Failed attempts on this entry

  always_ff @(posedge iCLK or negedge iRST_N) begin
    if (!iRST_N) begin
      state    <= stAdvance;  // Check table before first write
      idxReg   <= '0;
      retryCnt <= '0;
    end else begin
      case (state)
        stAdvance: state <= (idxReg == IdxW'(codecCfgPkg::tableSize)) ? stDone : stIssue;
        stIssue: begin
          if (!xferBusy) state <= stWait;
        end
        stWait: begin
          if (xferDone) begin
            if (xferAck) begin
              idxReg   <= idxReg + IdxW'(1);
              retryCnt <= '0;
              // Last entry goes through the check, others reissue at once
              state    <= (idxReg == IdxW'(codecCfgPkg::tableSize - 1)) ? stAdvance : stIssue;
            end else if (retryCnt == RetryW'(MAX_RETRY - 1)) begin
              state <= stFail;
            end else begin
              retryCnt <= retryCnt + RetryW'(1);
              state    <= stIssue;  // Same word again
            end
          end
        end
        default: state <= state;  // Done and fail hold until reset
      endcase
    end
  end

  assign idx       = idxReg;
  assign xferStart = (state == stIssue) && !xferBusy;
  assign xferWord  = {codecCfgPkg::codecAddrByte, regWord};
  assign cfgDone   = (state == stDone);
  assign cfgFail   = (state == stFail);

endmodule

//--- src/codecCfgTop.sv
`timescale 1ns/1ns
////////////////////
//  Codec config top
////////////////////

module codecCfgTop #(
  parameter int CLK_FREQ  = 24000000,
  parameter int I2C_FREQ  = 20000,
  parameter int MAX_RETRY = 3
) (
  input  logic iCLK,
  input  logic iRST_N,
  output logic i2cSclk,
  inout  wire  i2cSdat,
  output logic cfgDone,
  output logic cfgFail
);

  logic [codecCfgPkg::idxWidth-1:0]     idx;
  logic [codecCfgPkg::regWordWidth-1:0] regWord;
  logic [codecCfgPkg::xferWidth-1:0]    xferWord;
  logic                                 xferStart;
  logic                                 xferBusy;
  logic                                 xferDone;
  logic                                 xferAck;

  // Walks the table and handles retries
  codecCfgSequencer #(
    .MAX_RETRY(MAX_RETRY)
  ) codecCfgSequencer_inst (
    .iCLK     (iCLK),
    .iRST_N   (iRST_N),
    .idx      (idx),
    .regWord  (regWord),
    .xferStart(xferStart),
    .xferWord (xferWord),
    .xferBusy (xferBusy),
    .xferDone (xferDone),
    .xferAck  (xferAck),
    .cfgDone  (cfgDone),
    .cfgFail  (cfgFail)
  );

  codecRegTable codecRegTable_inst (
    .idx    (idx),
    .regWord(regWord)
  );

  // Bus side
  i2cWriteMaster #(
    .CLK_FREQ(CLK_FREQ),
    .I2C_FREQ(I2C_FREQ)
  ) i2cWriteMaster_inst (
    .iCLK     (iCLK),
    .iRST_N   (iRST_N),
    .xferStart(xferStart),
    .xferWord (xferWord),
    .xferBusy (xferBusy),
    .xferDone (xferDone),
    .xferAck  (xferAck),
    .i2cSclk  (i2cSclk),
    .i2cSdat  (i2cSdat)
  );

endmodule

//--- verification/i2cCodecModel.sv
`timescale 1ns/1ns
////////////////////
//  I2C codec slave model
////////////////////

module i2cCodecModel (
  input wire scl,
  inout wire sda
);

  localparam int LogDepth = 32;

  logic        ackDrive;      // Pull SDA low for ACK
  logic        inFrame;       // Between START and STOP
  int          bitIdx;        // SCL rises seen in this byte
  logic [7:0]  shiftIn;
  int          bytesRcvd;
  int          bytesAcked;
  logic        refusedSeen;   // A byte of this write was refused
  logic [23:0] frameData;     // Bytes of the current write, last byte lowest

  int          refuseCount;   // Upcoming data bytes to refuse
  logic        refuseAll;     // Refuse every byte
  int          writeCount;
  int          startCount;
  int          protoErrors;

  logic [23:0] recData [LogDepth];
  int          recBytes [LogDepth];
  int          recAcked [LogDepth];

  assign sda = ackDrive ? 1'b0 : 1'bz;  // Open drain

  task automatic clearLog();
    ackDrive    = 1'b0;
    inFrame     = 1'b0;
    bitIdx      = 0;
    shiftIn     = '0;
    bytesRcvd   = 0;
    bytesAcked  = 0;
    refusedSeen = 1'b0;
    frameData   = '0;
    refuseCount = 0;
    writeCount  = 0;
    startCount  = 0;
  endtask

  task automatic refuseNext(input int n);
    refuseCount = n;
  endtask

  task automatic setRefuseAll(input logic en);
    refuseAll = en;
  endtask

  // Store the finished or aborted write
  task automatic logWrite();
    if (writeCount < LogDepth) begin
      recData[writeCount]  = frameData;
      recBytes[writeCount] = bytesRcvd;
      recAcked[writeCount] = bytesAcked;
    end
    writeCount++;
  endtask

  initial begin
    protoErrors = 0;
    refuseAll   = 1'b0;
    clearLog();
  end

  ////////////////////
  // START and STOP

  always @(negedge sda) begin
    if (scl === 1'b1) begin
      startCount++;
      assert (!inFrame) else begin
        $display("ERROR %0t: START inside a write that had no STOP", $time);
        protoErrors++;
      end
      if (inFrame) logWrite();
      inFrame     = 1'b1;
      bitIdx      = 0;
      bytesRcvd   = 0;
      bytesAcked  = 0;
      refusedSeen = 1'b0;
      frameData   = '0;
    end
  end

  // STOP is legal on the first SCL high after a finished or refused write
  always @(posedge sda) begin
    if (scl === 1'b1) begin
      assert (inFrame && bitIdx == 1 && (bytesAcked == 3 || refusedSeen)) else begin
        $display("ERROR %0t: SDA rose with SCL high in the middle of a write", $time);
        protoErrors++;
      end
      if (inFrame) logWrite();
      inFrame = 1'b0;
    end
  end

  ////////////////////
  // Bit and ACK handling

  always @(posedge scl) begin
    if (inFrame) begin
      if (bitIdx < 8) shiftIn = {shiftIn[6:0], (sda !== 1'b0)};  // MSB first
      bitIdx++;
    end
  end

  always @(negedge scl) begin
    if (inFrame) begin
      if (bitIdx == 8) begin
        bytesRcvd++;
        frameData = {frameData[15:0], shiftIn};
        if (refuseAll) begin
          refusedSeen = 1'b1;
        end else if (refuseCount > 0 && bytesRcvd > 1) begin
          refuseCount--;  // Address byte always acked here
          refusedSeen = 1'b1;
        end else begin
          ackDrive = 1'b1;
          bytesAcked++;
        end
      end else if (bitIdx == 9) begin
        ackDrive = 1'b0;  // ACK slot over
        bitIdx   = 0;
      end
    end
  end

endmodule

//--- verification/codecCfgTb.sv
`timescale 1ns/1ns
////////////////////
//  Codec config testbench
////////////////////

module codecCfgTb;

  localparam int ClkFreq   = 25000000;
  localparam int I2cFreq   = 1250000;
  localparam int MaxRetry  = 3;
  localparam int TableSize = codecCfgPkg::tableSize;
  localparam int DoneLimit = 20000;  // Cycles to wait for a flag

  logic        iCLK;
  logic        iRST_N;
  wire         i2cSclk;
  wire         i2cSdat;
  wire         cfgDone;
  wire         cfgFail;
  int          errors;
  int          timeouts;      // Waits that ran out of cycles
  logic [31:0] lcgState;
  int          refusedEntry;
  int          startsAtDone;
  logic [15:0] expTable [TableSize];

  pullup (i2cSdat);  // Bus pull-up

  codecCfgTop #(
    .CLK_FREQ (ClkFreq),
    .I2C_FREQ (I2cFreq),
    .MAX_RETRY(MaxRetry)
  ) codecCfgTop_inst (
    .iCLK   (iCLK),
    .iRST_N (iRST_N),
    .i2cSclk(i2cSclk),
    .i2cSdat(i2cSdat),
    .cfgDone(cfgDone),
    .cfgFail(cfgFail)
  );

  i2cCodecModel codecModel (
    .scl(i2cSclk),
    .sda(i2cSdat)
  );

  initial begin
    iCLK = 1'b0;
    forever #20 iCLK = ~iCLK;  // 40 ns period
  end

  function automatic logic [31:0] lcgNext(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  task automatic expectTrue(input logic cond, input string msg);
    assert (cond) else begin
      $display("ERROR %0t: %s", $time, msg);
      errors++;
    end
  endtask

  // Idle bus and low flags through reset and just after
  task automatic checkIdle();
    expectTrue(i2cSclk === 1'b1, "SCL not high around reset");
    expectTrue(i2cSdat === 1'b1, "SDA not released around reset");
    expectTrue(cfgDone === 1'b0 && cfgFail === 1'b0, "flags not low around reset");
  endtask

  task automatic applyReset(input logic refuseEverything);
    @(negedge iCLK);
    iRST_N = 1'b0;
    codecModel.clearLog();
    codecModel.setRefuseAll(refuseEverything);
    repeat (5) begin
      @(negedge iCLK);
      checkIdle();
    end
    iRST_N = 1'b1;
    @(negedge iCLK);
    checkIdle();
  endtask

  task automatic waitFlag();
    int n;
    n = 0;
    while (!(cfgDone || cfgFail) && n < DoneLimit) begin
      @(negedge iCLK);
      n++;
    end
    if (!(cfgDone || cfgFail)) begin
      $display("Timed out waiting for cfgDone or cfgFail");
      timeouts++;
    end
  endtask

  task automatic waitWrites(input int count);
    int n;
    n = 0;
    while (codecModel.writeCount < count && n < DoneLimit) begin
      @(negedge iCLK);
      n++;
    end
    if (codecModel.writeCount < count) begin
      $display("Timed out waiting for the codec model to see %0d writes", count);
      timeouts++;
    end
  endtask

  // Bus must stay quiet and the end flag must hold
  task automatic watchIdleBus(input int cycles, input logic expDone);
    int n;
    n = 0;
    startsAtDone = codecModel.startCount;
    while (n < cycles) begin
      @(negedge iCLK);
      expectTrue(i2cSclk === 1'b1 && i2cSdat === 1'b1, "bus not idle after the end");
      expectTrue(cfgDone === expDone && cfgFail === !expDone, "end flag did not hold");
      n++;
    end
    expectTrue(codecModel.startCount == startsAtDone, "START seen after the end");
  endtask

  task automatic checkComplete(input int k, input int entry);
    expectTrue(codecModel.recAcked[k] == 3, $sformatf("write %0d not fully acked", k));
    expectTrue(codecModel.recData[k] == {8'h34, expTable[entry]},
               $sformatf("write %0d got %h, expected entry %0d", k, codecModel.recData[k],
                         entry));
  endtask

  ////////////////////
  // Scenarios

  // Codec acks every byte
  task automatic runCleanConfig();
    applyReset(1'b0);
    waitFlag();
    if (timeouts != 0) return;
    expectTrue(cfgDone === 1'b1 && cfgFail === 1'b0, "clean run did not end in done");
    watchIdleBus(300, 1'b1);
    expectTrue(codecModel.writeCount == TableSize, "clean run write count wrong");
    for (int k = 0; k < TableSize; k++) checkComplete(k, k);
  endtask

  // One data byte refused at an LCG-picked entry
  task automatic runRetryConfig();
    lcgState     = lcgNext(lcgState);
    refusedEntry = int'(lcgState[23:16]) % TableSize;
    applyReset(1'b0);
    waitWrites(refusedEntry);
    if (timeouts != 0) return;
    codecModel.refuseNext(1);  // Hits the next write
    waitFlag();
    if (timeouts != 0) return;
    expectTrue(cfgDone === 1'b1 && cfgFail === 1'b0, "retry run did not end in done");
    watchIdleBus(300, 1'b1);
    expectTrue(codecModel.writeCount == TableSize + 1, "retry run write count wrong");
    for (int k = 0; k <= TableSize; k++) begin
      if (k < refusedEntry) begin
        checkComplete(k, k);
      end else if (k == refusedEntry) begin
        expectTrue(codecModel.recAcked[k] == 1 && codecModel.recBytes[k] == 2,
                   "refused write not cut after the first data byte");
        expectTrue(codecModel.recData[k][15:0] == {8'h34, expTable[k][15:8]},
                   "refused write bytes wrong");
      end else begin
        checkComplete(k, k - 1);  // Retry and later entries sit one slot on
      end
    end
  endtask

  // Codec refuses every byte
  task automatic runRefusedConfig();
    applyReset(1'b1);
    waitFlag();
    if (timeouts != 0) return;
    expectTrue(cfgFail === 1'b1 && cfgDone === 1'b0, "refusing codec did not end in fail");
    watchIdleBus(300, 1'b0);
    expectTrue(codecModel.writeCount == MaxRetry, "attempt count wrong");
    for (int k = 0; k < MaxRetry; k++) begin
      expectTrue(codecModel.recBytes[k] == 1 && codecModel.recData[k][7:0] == 8'h34,
                 "failed attempt not stopped after address byte");
    end
    codecModel.setRefuseAll(1'b0);
  endtask

  initial begin
    expTable = '{16'h1E00, 16'h009A, 16'h029A, 16'h0479, 16'h0679, 16'h08D2,
                 16'h0A06, 16'h0C00, 16'h0E01, 16'h1009, 16'h1201};
    errors   = 0;
    timeouts = 0;
    iRST_N   = 1'b0;
    lcgState = 32'h0b6557fc;

    runCleanConfig();
    if (timeouts == 0) runRetryConfig();
    if (timeouts == 0) runRefusedConfig();

    if (timeouts == 0) expectTrue(!codecModel.inFrame, "last write never ended with STOP");
    $display("Errors: testbench %0d, protocol %0d, timeouts %0d", errors,
             codecModel.protoErrors, timeouts);
    if (timeouts == 0 && errors == 0 && codecModel.protoErrors == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

//--- filelist.f
src/codecCfgPkg.sv
src/codecRegTable.sv
src/i2cWriteMaster.sv
src/codecCfgSequencer.sv
src/codecCfgTop.sv
verification/i2cCodecModel.sv
verification/codecCfgTb.sv

//--- Makefile
VERILATOR ?= verilator
FLAGS     ?= --binary --timing --assert
TOP       ?= codecCfgTb
FILELIST  ?= filelist.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR) -o simv
	./$(OBJDIR)/simv | tee $(LOG)
	grep -q "PASS: all tests" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
